// ==== verilog/dp_pkg.sv ====
`default_nettype none

package dp_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================

    localparam int data_w     = 8;
    localparam int port_w     = 2;
    localparam int len_w      = 16;
    localparam int cnt_w      = 32;
    localparam int entropy_w  = 12;
    localparam int cfg_addr_w = 4;
    localparam int cfg_data_w = 32;

    // Port codes
    // Network side
    localparam logic [port_w-1:0] port_cmac0 = 2'd0;
    localparam logic [port_w-1:0] port_cmac1 = 2'd1;
    // Host side, these get RSS metadata
    localparam logic [port_w-1:0] port_host0 = 2'd2;
    localparam logic [port_w-1:0] port_host1 = 2'd3;

    // ========================================================================
    // Config register map
    // ========================================================================

    // Remap entries sit at base .. base+3, one per header destination
    localparam logic [cfg_addr_w-1:0] cfg_remap_base = 4'd0;
    localparam int                    remap_depth    = 4;
    // Truncation, bit 0 enable, bits 31:16 length
    localparam logic [cfg_addr_w-1:0] cfg_trunc      = 4'd4;

    localparam logic [len_w-1:0] trunc_len_default = 16'd64;

    // Match-action opcode, header bits 7:6
    typedef enum logic [1:0] {
        op_forward  = 2'd0,
        op_loopback = 2'd1,
        op_drop     = 2'd2,
        op_reserved = 2'd3
    } opcode_t;

endpackage

`default_nettype wire

// ==== verilog/dp_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module dp_decode (
    input  logic                          clk,
    input  logic                          reset,
    // Ingress byte stream
    input  logic                          in_valid,
    input  logic                          in_sop,
    input  logic                          in_eop,
    input  logic [dp_pkg::data_w-1:0]     in_data,
    input  logic [dp_pkg::port_w-1:0]     in_port,
    // Config bus
    input  logic                          cfg_write,
    input  logic [dp_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [dp_pkg::cfg_data_w-1:0] cfg_wdata,
    // To execute
    output logic                          dec_valid,
    output logic                          dec_sop,
    output logic                          dec_eop,
    output logic [dp_pkg::data_w-1:0]     dec_data,
    output logic [dp_pkg::port_w-1:0]     dec_dst,
    output logic [dp_pkg::port_w-1:0]     dec_src,
    output logic                          dec_drop
);

    import dp_pkg::*;

    // Destination remap table, indexed by header bits 1:0
    logic [port_w-1:0] remap [remap_depth];

    opcode_t           hdr_op;
    logic [port_w-1:0] hdr_dst;
    logic              hdr_drop;
    logic [port_w-1:0] remap_idx;
    logic              remap_hit;
    logic              hdr_take;

    // Header byte is the first valid byte of each packet
    assign hdr_take = in_valid && in_sop;
    assign hdr_op   = opcode_t'(in_data[7:6]);

    // Config writes into the remap window only
    assign remap_idx = port_w'(cfg_addr - cfg_remap_base);
    assign remap_hit = cfg_write && (cfg_addr >= cfg_remap_base)
                       && (cfg_addr < cfg_remap_base + cfg_addr_w'(remap_depth));

    // Opcode decode into destination and drop flag
    always_comb begin
        hdr_dst  = in_port;
        hdr_drop = 1'b0;
        case (hdr_op)
            op_forward:  hdr_dst = remap[in_data[port_w-1:0]];
            op_loopback: hdr_dst = in_port;
            // op_drop and op_reserved both discard
            default:     hdr_drop = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // Identity map after reset
            for (int i = 0; i < remap_depth; i++) begin
                remap[i] <= port_w'(i);
            end
        end else if (remap_hit) begin
            remap[remap_idx] <= cfg_wdata[port_w-1:0];
        end
    end

    // ========================================================================
    // Output stage
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_sop   <= 1'b0;
            dec_eop   <= 1'b0;
            dec_drop  <= 1'b0;
        end else begin
            dec_valid <= in_valid;
            dec_sop   <= hdr_take;
            dec_eop   <= in_valid && in_eop;
            // Drop flag holds for the rest of the packet
            if (hdr_take) begin
                dec_drop <= hdr_drop;
            end
        end
    end

    // Payload, destination and source held from the header byte
    always_ff @(posedge clk) begin
        dec_data <= in_data;
        if (hdr_take) begin
            dec_dst <= hdr_dst;
            dec_src <= in_port;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dp_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module dp_execute (
    input  logic                          clk,
    input  logic                          reset,
    // From decode
    input  logic                          dec_valid,
    input  logic                          dec_sop,
    input  logic                          dec_eop,
    input  logic [dp_pkg::data_w-1:0]     dec_data,
    input  logic [dp_pkg::port_w-1:0]     dec_dst,
    input  logic [dp_pkg::port_w-1:0]     dec_src,
    input  logic                          dec_drop,
    // Config bus
    input  logic                          cfg_write,
    input  logic [dp_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [dp_pkg::cfg_data_w-1:0] cfg_wdata,
    // To result
    output logic                          exe_valid,
    output logic                          exe_sop,
    output logic                          exe_eop,
    output logic [dp_pkg::data_w-1:0]     exe_data,
    output logic [dp_pkg::port_w-1:0]     exe_dst,
    output logic [dp_pkg::port_w-1:0]     exe_src
);

    import dp_pkg::*;

    // Programmed truncation config
    logic             trunc_en;
    logic [len_w-1:0] trunc_len;
    // Per-packet copy, latched at sop
    logic             pkt_en;
    logic [len_w-1:0] pkt_len;
    // Bytes of the current packet seen so far
    logic [len_w-1:0] byte_cnt;

    logic             use_en;
    logic [len_w-1:0] use_len;
    logic [len_w-1:0] byte_idx;
    logic             at_len;
    logic             keep;

    // The sop byte already sees the programmed value
    assign use_en  = dec_sop ? trunc_en  : pkt_en;
    assign use_len = dec_sop ? trunc_len : pkt_len;
    // One-based position, saturates on very long packets
    assign byte_idx = dec_sop ? len_w'(1) :
                      (&byte_cnt) ? byte_cnt : byte_cnt + 1'b1;

    assign at_len = use_en && (byte_idx == use_len);
    assign keep   = !dec_drop && !(use_en && (byte_idx > use_len));

    always_ff @(posedge clk) begin
        if (reset) begin
            trunc_en  <= 1'b0;
            trunc_len <= trunc_len_default;
            pkt_en    <= 1'b0;
            pkt_len   <= trunc_len_default;
            byte_cnt  <= '0;
        end else begin
            if (cfg_write && (cfg_addr == cfg_trunc)) begin
                trunc_en  <= cfg_wdata[0];
                trunc_len <= cfg_wdata[cfg_data_w-1 -: len_w];
            end
            if (dec_valid && dec_sop) begin
                pkt_en  <= trunc_en;
                pkt_len <= trunc_len;
            end
            if (dec_valid) begin
                byte_cnt <= byte_idx;
            end
        end
    end

    // ========================================================================
    // Output stage
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
            exe_sop   <= 1'b0;
            exe_eop   <= 1'b0;
        end else begin
            exe_valid <= dec_valid && keep;
            exe_sop   <= dec_valid && keep && dec_sop;
            // Byte L closes a truncated packet
            exe_eop   <= dec_valid && keep && (dec_eop || at_len);
        end
    end

    always_ff @(posedge clk) begin
        exe_data <= dec_data;
        exe_dst  <= dec_dst;
        exe_src  <= dec_src;
    end

endmodule

`default_nettype wire

// ==== verilog/dp_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module dp_result (
    input  logic                         clk,
    input  logic                         reset,
    // From execute
    input  logic                         exe_valid,
    input  logic                         exe_sop,
    input  logic                         exe_eop,
    input  logic [dp_pkg::data_w-1:0]    exe_data,
    input  logic [dp_pkg::port_w-1:0]    exe_dst,
    input  logic [dp_pkg::port_w-1:0]    exe_src,
    // Egress stream
    output logic                         out_valid,
    output logic                         out_sop,
    output logic                         out_eop,
    output logic [dp_pkg::data_w-1:0]    out_data,
    output logic [dp_pkg::port_w-1:0]    out_port,
    // RSS metadata
    output logic                         rss_enable,
    output logic [dp_pkg::entropy_w-1:0] rss_entropy,
    // Delivery counters
    output logic [dp_pkg::cnt_w-1:0]     pkt_count,
    output logic [dp_pkg::cnt_w-1:0]     byte_count
);

    import dp_pkg::*;

    logic                 to_host;
    logic [entropy_w-1:0] src_entropy;

    // Host ports get RSS metadata, network ports do not
    assign to_host = (exe_dst == port_host0) || (exe_dst == port_host1);

    // Entropy is just the ingress port, zero extended
    assign src_entropy = {{(entropy_w - port_w){1'b0}}, exe_src};

    // ========================================================================
    // Egress register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            out_sop    <= 1'b0;
            out_eop    <= 1'b0;
            rss_enable <= 1'b0;
        end else begin
            out_valid  <= exe_valid;
            out_sop    <= exe_valid && exe_sop;
            out_eop    <= exe_valid && exe_eop;
            rss_enable <= exe_valid && to_host;
        end
    end

    always_ff @(posedge clk) begin
        out_data    <= exe_data;
        out_port    <= exe_dst;
        rss_entropy <= src_entropy;
    end

    // ========================================================================
    // Counters
    // ========================================================================

    // Count what actually leaves, one cycle behind the egress register
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_count  <= '0;
            byte_count <= '0;
        end else begin
            if (out_valid) begin
                byte_count <= byte_count + 1'b1;
            end
            // A packet counts at its delivered eop
            if (out_valid && out_eop) begin
                pkt_count <= pkt_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dp_top (
    input  logic                          clk,
    input  logic                          reset,
    // Ingress
    input  logic                          in_valid,
    input  logic                          in_sop,
    input  logic                          in_eop,
    input  logic [dp_pkg::data_w-1:0]     in_data,
    input  logic [dp_pkg::port_w-1:0]     in_port,
    // Config
    input  logic                          cfg_write,
    input  logic [dp_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [dp_pkg::cfg_data_w-1:0] cfg_wdata,
    // Egress
    output logic                          out_valid,
    output logic                          out_sop,
    output logic                          out_eop,
    output logic [dp_pkg::data_w-1:0]     out_data,
    output logic [dp_pkg::port_w-1:0]     out_port,
    output logic                          rss_enable,
    output logic [dp_pkg::entropy_w-1:0]  rss_entropy,
    // Counters
    output logic [dp_pkg::cnt_w-1:0]      pkt_count,
    output logic [dp_pkg::cnt_w-1:0]      byte_count
);

    import dp_pkg::*;

    // Decode to execute
    logic              dec_valid;
    logic              dec_sop;
    logic              dec_eop;
    logic [data_w-1:0] dec_data;
    logic [port_w-1:0] dec_dst;
    logic [port_w-1:0] dec_src;
    logic              dec_drop;

    // Execute to result
    logic              exe_valid;
    logic              exe_sop;
    logic              exe_eop;
    logic [data_w-1:0] exe_data;
    logic [port_w-1:0] exe_dst;
    logic [port_w-1:0] exe_src;

    // Three register stages, header parse then truncate then egress
    dp_decode u_decode (
        .clk, .reset,
        .in_valid, .in_sop, .in_eop, .in_data, .in_port,
        .cfg_write, .cfg_addr, .cfg_wdata,
        .dec_valid, .dec_sop, .dec_eop, .dec_data, .dec_dst, .dec_src, .dec_drop
    );

    dp_execute u_execute (
        .clk, .reset,
        .dec_valid, .dec_sop, .dec_eop, .dec_data, .dec_dst, .dec_src, .dec_drop,
        .cfg_write, .cfg_addr, .cfg_wdata,
        .exe_valid, .exe_sop, .exe_eop, .exe_data, .exe_dst, .exe_src
    );

    dp_result u_result (
        .clk, .reset,
        .exe_valid, .exe_sop, .exe_eop, .exe_data, .exe_dst, .exe_src,
        .out_valid, .out_sop, .out_eop, .out_data, .out_port,
        .rss_enable, .rss_entropy,
        .pkt_count, .byte_count
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Synchronous reset, held for the first 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_dp.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dp;

    import dp_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_sop;
    logic                  in_eop;
    logic [data_w-1:0]     in_data;
    logic [port_w-1:0]     in_port;
    logic                  cfg_write;
    logic [cfg_addr_w-1:0] cfg_addr;
    logic [cfg_data_w-1:0] cfg_wdata;
    logic                  out_valid;
    logic                  out_sop;
    logic                  out_eop;
    logic [data_w-1:0]     out_data;
    logic [port_w-1:0]     out_port;
    logic                  rss_enable;
    logic [entropy_w-1:0]  rss_entropy;
    logic [cnt_w-1:0]      pkt_count;
    logic [cnt_w-1:0]      byte_count;

    // Config copy kept in step with every write
    logic [port_w-1:0] remap_model [remap_depth];
    logic              trunc_en_model;
    logic [len_w-1:0]  trunc_len_model;
    // Bytes of the packet being sent
    logic [data_w-1:0] pkt_bytes [64];
    // Expected egress entries packed as {sop, eop, rss, src, port, data}
    logic [14:0]       exp_q [$];

    integer seed = 51521;
    int     error_count = 0;
    int     check_count = 0;
    int     bytes_sent = 0;
    int     cycle_count = 0;
    int     exp_pkts = 0;
    int     exp_bytes = 0;

    tb_clock u_clock (.clk, .reset);

    dp_top u_dut (
        .clk, .reset,
        .in_valid, .in_sop, .in_eop, .in_data, .in_port,
        .cfg_write, .cfg_addr, .cfg_wdata,
        .out_valid, .out_sop, .out_eop, .out_data, .out_port,
        .rss_enable, .rss_entropy,
        .pkt_count, .byte_count
    );

    // ========================================================================
    // Helpers and reference model
    // ========================================================================

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Expected egress bytes for the packet now in pkt_bytes
    function automatic void predict_packet(input logic [port_w-1:0] src, input int len);
        opcode_t           op;
        logic [port_w-1:0] dst;
        logic              rss;
        int                out_len;
        int                i;
        op = opcode_t'(pkt_bytes[0][7:6]);
        // Nothing leaves for discarded packets
        if (op == op_drop || op == op_reserved) begin
            return;
        end
        dst = (op == op_forward) ? remap_model[pkt_bytes[0][1:0]] : src;
        rss = (dst == port_host0) || (dst == port_host1);
        out_len = len;
        // Long packets are cut to L bytes
        if (trunc_en_model && len > int'(trunc_len_model)) begin
            out_len = int'(trunc_len_model);
        end
        for (i = 0; i < out_len; i++) begin
            exp_q.push_back({i == 0, i == out_len - 1, rss, src, dst, pkt_bytes[i]});
        end
        exp_pkts++;
        exp_bytes += out_len;
    endfunction

    // ========================================================================
    // Stimulus tasks that all drive on the falling edge
    // ========================================================================

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic write_config(input logic [cfg_addr_w-1:0] addr, input logic [31:0] data);
        // Ingress stays idle during a config write
        in_valid  = 1'b0;
        in_sop    = 1'b0;
        in_eop    = 1'b0;
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_write = 1'b0;
        if (addr == cfg_trunc) begin
            trunc_en_model  = data[0];
            trunc_len_model = data[31:16];
        end else if (int'(addr) < remap_depth) begin
            remap_model[port_w'(addr - cfg_remap_base)] = data[port_w-1:0];
        end
    endtask

    task automatic send_packet(input logic [port_w-1:0] src, input opcode_t op,
                               input logic [port_w-1:0] dst, input int len, input bit gaps);
        int i;
        // Header byte with the opcode on top and the destination in the low bits
        pkt_bytes[0] = {op, 4'(rand_range(0, 15)), dst};
        for (i = 1; i < len; i++) begin
            pkt_bytes[i] = 8'(rand_range(0, 255));
        end
        predict_packet(src, len);
        bytes_sent += len;
        for (i = 0; i < len; i++) begin
            // Occasional hole inside the packet
            if (gaps && i > 0 && rand_range(0, 3) == 0) begin
                idle_cycles(1);
            end
            in_valid = 1'b1;
            in_sop   = (i == 0);
            in_eop   = (i == len - 1);
            in_data  = pkt_bytes[i];
            in_port  = src;
            @(negedge clk);
        end
    endtask

    // ========================================================================
    // Compare process and watchdog
    // ========================================================================

    always @(negedge clk) begin : compare
        logic [14:0] exp_entry;
        if (!reset && out_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Output byte %h on port %0d arrived with nothing expected",
                         out_data, out_port);
                error_count++;
            end
            if (exp_q.size() > 0) begin
                exp_entry = exp_q.pop_front();
                check_field("out_data", 32'(out_data), 32'(exp_entry[7:0]));
                check_field("out_port", 32'(out_port), 32'(exp_entry[9:8]));
                check_field("rss_enable", 32'(rss_enable), 32'(exp_entry[12]));
                check_field("out_eop", 32'(out_eop), 32'(exp_entry[13]));
                check_field("out_sop", 32'(out_sop), 32'(exp_entry[14]));
                // Entropy only matters on host ports
                if (exp_entry[12]) begin
                    check_field("rss_entropy", 32'(rss_entropy), 32'(exp_entry[11:10]));
                end
            end
        end else if (!reset) begin
            assert (!out_sop && !out_eop && !rss_enable) else begin
                $display("Egress strobe high while out_valid is low");
                error_count++;
            end
        end
    end

    // Limit grows with the traffic sent
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 4 * bytes_sent + 500) begin
            $display("Timeout after %0d cycles, %0d bytes never came out",
                     cycle_count, exp_q.size());
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("Errors found");
            $finish;
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int src;
        int dst;
        int n;
        int k;
        in_valid  = 1'b0;
        in_sop    = 1'b0;
        in_eop    = 1'b0;
        in_data   = '0;
        in_port   = '0;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        for (k = 0; k < remap_depth; k++) begin
            remap_model[k] = port_w'(k);
        end
        trunc_en_model  = 1'b0;
        trunc_len_model = trunc_len_default;
        do @(negedge clk); while (reset !== 1'b0);

        // Identity remap from every source to every destination
        for (src = 0; src < 4; src++) begin
            for (dst = 0; dst < 4; dst++) begin
                send_packet(port_w'(src), op_forward, port_w'(dst), rand_range(2, 20), 1'b1);
            end
        end
        idle_cycles(4);

        // Reversed remap entries, no entry left at identity
        for (k = 0; k < remap_depth; k++) begin
            write_config(cfg_remap_base + cfg_addr_w'(k), 32'(remap_depth - 1 - k));
        end
        // Forward and loopback alternate on every ingress port
        for (n = 0; n < 16; n++) begin
            send_packet(port_w'((n / 2) % 4), (n % 2) ? op_loopback : op_forward,
                        port_w'(rand_range(0, 3)), rand_range(2, 16), 1'b1);
        end
        idle_cycles(4);

        // Egress truncation with a new length before every group
        for (n = 0; n < 12; n++) begin
            write_config(cfg_trunc, {16'(rand_range(3, 40)), 15'd0, 1'b1});
            for (k = 0; k < 3; k++) begin
                send_packet(port_w'(rand_range(0, 3)), op_forward,
                            port_w'(rand_range(0, 3)), rand_range(2, 60), 1'b1);
            end
        end
        write_config(cfg_trunc, {trunc_len_default, 15'd0, 1'b0});

        // Drops packed back to back with surviving traffic
        for (n = 0; n < 24; n++) begin
            send_packet(port_w'(rand_range(0, 3)), opcode_t'(rand_range(0, 3)),
                        port_w'(rand_range(0, 3)), rand_range(2, 12), 1'b0);
        end
        idle_cycles(1);

        // Three pipeline stages, and the counters trail egress by one more cycle
        repeat (5) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("Expected bytes left over after the drain");
            error_count++;
        end
        check_field("pkt_count", pkt_count, 32'(exp_pkts));
        check_field("byte_count", byte_count, 32'(exp_bytes));

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/dp_pkg.sv
verilog/dp_decode.sv
verilog/dp_execute.sv
verilog/dp_result.sv
verilog/dp_top.sv
tests/tb_clock.sv
tests/tb_dp.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_dp
FILELIST   = files.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then search the log for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
